//--- verilog.f
tlp_pkg.sv
mempost_cfg_pkg.sv
sync_fifo.sv
counter_source.sv
mem_write_requestor.sv
tx_credit_arbiter.sv
mempost_top.sv
tb_mempost.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it; a failing run exits non-zero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mempost -f verilog.f -o tb_mempost
./obj_dir/tb_mempost

//--- tb_mempost.sv
`timescale 1ns/1ps

module tb_mempost;
	import tlp_pkg::*;
	import mempost_cfg_pkg::*;

	localparam int N_CH            = 3;
	localparam int N_ROWS          = 7;
	localparam int COLLECT_TIMEOUT = 20000; // cycles per collect
	localparam int QUIET_CYCLES    = 1000;  // no-sop window when credits run out

	logic        w_AppClk = 1'b0;
	logic        i_rst;
	logic        i_enable;
	mps_code_t   i_mps_code;
	req_id_t     i_requestor_id;
	cred_hdr_t   i_cred_lim_ph;
	cred_data_t  i_cred_lim_pd;
	logic        o_tx_valid;
	logic        o_tx_sop;
	logic        o_tx_eop;
	qword_t      o_tx_data;
	logic        i_tx_ready;
	cred_hdr_t   o_cred_cons_ph;
	cred_data_t  o_cred_cons_pd;

	// stimulus table
	string        row_name  [N_ROWS] = '{"mps128_flow", "mps256_flow", "mps512_wrap",
		"mps_code5", "ready_random", "ph_limit3", "pd_starved"};
	mps_code_t    row_code  [N_ROWS] = '{3'd0, 3'd1, 3'd2, 3'd5, 3'd1, 3'd0, 3'd1};
	cred_hdr_t    row_ph    [N_ROWS] = '{8'd200, 8'd200, 8'd200, 8'd200, 8'd200, 8'd3, 8'd200};
	cred_data_t   row_pd    [N_ROWS] = '{12'd4000, 12'd4000, 12'd4000, 12'd4000, 12'd4000,
		12'd4000, 12'd10};
	cred_data_t   row_raise [N_ROWS] = '{12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd96};
	int unsigned  row_pct   [N_ROWS] = '{0, 0, 0, 0, 40, 0, 0}; // ready-low percent
	int           row_n     [N_ROWS] = '{12, 12, 30, 9, 15, 3, 0}; // 0 means starved until pd raise

	integer  seed;
	string   cur_name;
	req_id_t cur_rid;
	int      row_pyld;          // payload bytes for the row's code
	qword_t  exp_cnt [N_CH];    // next counter value per channel
	tag_t    exp_tag [N_CH];
	int      exp_ofs [N_CH];    // byte offset inside the window
	int      ch_tlps [N_CH];
	logic    in_tlp;
	logic    first_sop_seen;
	int      beat_idx;
	int      cur_ch;
	qword_t  hdr0_q;            // beat 0 held until the address names the channel
	int      tlps_seen;
	int      sum_pd;            // data credits summed over seen tlps

	mempost_top #(
		.N_CH       (N_CH),
		.FIFO_DEPTH (128)
	) dut (
		.w_AppClk       (w_AppClk),
		.i_rst          (i_rst),
		.i_enable       (i_enable),
		.i_mps_code     (i_mps_code),
		.i_requestor_id (i_requestor_id),
		.i_cred_lim_ph  (i_cred_lim_ph),
		.i_cred_lim_pd  (i_cred_lim_pd),
		.o_tx_valid     (o_tx_valid),
		.o_tx_sop       (o_tx_sop),
		.o_tx_eop       (o_tx_eop),
		.o_tx_data      (o_tx_data),
		.i_tx_ready     (i_tx_ready),
		.o_cred_cons_ph (o_cred_cons_ph),
		.o_cred_cons_pd (o_cred_cons_pd)
	);

	always #20 w_AppClk = ~w_AppClk; // 40 ns period

	task automatic end_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "simulation halted after an error");
	endtask

	task automatic report_problem(input string why);
		$display("%s", why);
		end_with_failure();
	endtask

	task automatic check_qword(input string name, input qword_t exp, input qword_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_tag(input string name, input tag_t exp, input tag_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_hdr(input string name, input cred_hdr_t exp, input cred_hdr_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_data(input string name, input cred_data_t exp, input cred_data_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			end_with_failure();
		end
	endtask

	// unknown max payload codes act as 128
	function automatic int payload_for_code(input mps_code_t code);
		case (code)
			3'd1:    return 256;
			3'd2:    return 512;
			default: return 128;
		endcase
	endfunction

	// tlps that the limits allow from zero consumed
	function automatic int credit_room(input int ph, input int pd, input int need);
		return (ph < pd / need) ? ph : pd / need;
	endfunction

	task automatic clear_monitor();
		for (int c = 0; c < N_CH; c++) begin
			exp_cnt[c] = '0;
			exp_tag[c] = '0;
			exp_ofs[c] = 0;
			ch_tlps[c] = 0;
		end
		in_tlp         = 1'b0;
		first_sop_seen = 1'b0;
		tlps_seen      = 0;
		sum_pd         = 0;
	endtask

	// reassembles accepted beats into tlps
	task automatic take_beat(input qword_t data, input logic sop, input logic eop);
		dw_t  addr;
		dw_t  exp_addr;
		logic last;
		if (!in_tlp) begin
			if (!sop) report_problem({cur_name, ": beat outside any TLP has no sop"});
			if (eop) report_problem({cur_name, ": eop on the first header beat"});
			in_tlp         = 1'b1;
			beat_idx       = 0;
			hdr0_q         = data;
			first_sop_seen = 1'b1;
		end else if (sop) begin
			report_problem({cur_name, ": sop inside an open TLP, TLPs interleaved"});
		end else begin
			beat_idx++;
			if (beat_idx == 1) begin
				addr = data[31:0];
				if (addr < ADDR_BASE || addr >= ADDR_BASE + dw_t'(N_CH * CH_WINDOW_BYTES))
					report_problem({cur_name, ": TLP address outside every channel window"});
				cur_ch   = int'((addr - ADDR_BASE) / dw_t'(CH_WINDOW_BYTES));
				exp_addr = ADDR_BASE + dw_t'(cur_ch * CH_WINDOW_BYTES) + dw_t'(exp_ofs[cur_ch]);
				check_tag({cur_name, " tag"}, exp_tag[cur_ch], hdr0_q[47:40]);
				check_qword({cur_name, " header beat 0"}, {cur_rid, exp_tag[cur_ch], 4'hF, 4'hF,
					FMT_MWR_3DW, TYPE_MEM, 14'd0, tlp_len_t'(row_pyld / 4)}, hdr0_q);
				check_qword({cur_name, " header beat 1"}, {32'h0, exp_addr}, data);
				if (eop) report_problem({cur_name, ": eop on the address beat"});
			end else begin
				check_qword({cur_name, " payload"}, exp_cnt[cur_ch], data);
				exp_cnt[cur_ch] = exp_cnt[cur_ch] + 64'd1; // counter runs on across tlps
				last = (beat_idx == 1 + row_pyld / 8);
				if (eop != last) report_problem({cur_name, ": eop not on the last data beat"});
				if (eop) begin
					in_tlp          = 1'b0;
					exp_tag[cur_ch] = exp_tag[cur_ch] + 8'd1;
					exp_ofs[cur_ch] = (exp_ofs[cur_ch] + row_pyld) % CH_WINDOW_BYTES; // wrap
					ch_tlps[cur_ch]++;
					tlps_seen++;
					sum_pd = sum_pd + row_pyld / CRED_DATA_BYTES; // data credits of one tlp
				end
			end
		end
	endtask

	// ready driven at the falling edge and sampled once settled
	task automatic step_cycle(input int unsigned pct);
		int unsigned r;
		@(negedge w_AppClk);
		if (pct > 0) begin
			r          = $unsigned($random(seed)) % 100;
			i_tx_ready = (r >= pct);
		end else begin
			i_tx_ready = 1'b1;
		end
		#1;
		if (!first_sop_seen && o_tx_valid && !o_tx_sop)
			report_problem({cur_name, ": valid raised before the first sop"});
		if (o_tx_valid && i_tx_ready) begin
			take_beat(o_tx_data, o_tx_sop, o_tx_eop); // transfers at the next rising edge
		end
	endtask

	task automatic apply_reset(input mps_code_t code, input cred_hdr_t ph, input cred_data_t pd);
		@(negedge w_AppClk);
		i_rst          = 1'b1;
		i_enable       = 1'b0;
		i_tx_ready     = 1'b1;
		i_mps_code     = code;
		i_cred_lim_ph  = ph;
		i_cred_lim_pd  = pd;
		i_requestor_id = cur_rid;
		repeat (3) @(negedge w_AppClk);
		i_rst = 1'b0;
	endtask

	task automatic check_idle();
		repeat (4) begin
			@(negedge w_AppClk);
			#1;
			check_flag({cur_name, " valid after reset"}, 1'b0, o_tx_valid);
			check_hdr({cur_name, " PH after reset"}, 8'd0, o_cred_cons_ph);
			check_data({cur_name, " PD after reset"}, 12'd0, o_cred_cons_pd);
		end
	endtask

	task automatic collect_tlps(input int n_want, input int unsigned pct);
		int cyc;
		cyc = 0;
		while (tlps_seen < n_want) begin
			if (cyc == COLLECT_TIMEOUT)
				report_problem($sformatf("%s: timeout with %0d of %0d TLPs received",
					cur_name, tlps_seen, n_want));
			step_cycle(pct);
			cyc++;
		end
	endtask

	task automatic expect_quiet(input int unsigned pct);
		for (int k = 0; k < QUIET_CYCLES; k++) begin
			step_cycle(pct);
			if (o_tx_valid && o_tx_sop)
				report_problem({cur_name, ": sop seen although credits are used up"});
		end
	endtask

	task automatic check_credits();
		check_hdr({cur_name, " consumed PH"}, cred_hdr_t'(tlps_seen), o_cred_cons_ph);
		check_data({cur_name, " consumed PD"}, cred_data_t'(sum_pd), o_cred_cons_pd);
	endtask

	task automatic run_row(input int i);
		int need;
		int allowed;
		int target;
		cur_name = row_name[i];
		cur_rid  = req_id_t'(32'h0A00 + i);
		row_pyld = payload_for_code(row_code[i]);
		need     = row_pyld / CRED_DATA_BYTES;
		allowed  = credit_room(int'(row_ph[i]), int'(row_pd[i]), need);
		target   = row_n[i];
		clear_monitor();
		apply_reset(row_code[i], row_ph[i], row_pd[i]);
		check_idle();
		@(negedge w_AppClk);
		i_enable = 1'b1;
		if (target == 0) begin
			expect_quiet(row_pct[i]);  // starved so no grant is possible
			check_credits();
			@(negedge w_AppClk);
			i_cred_lim_pd = row_raise[i];
			allowed       = credit_room(int'(row_ph[i]), int'(row_raise[i]), need);
			target        = allowed;
		end
		collect_tlps(target, row_pct[i]);
		if (target == allowed) begin
			expect_quiet(row_pct[i]);  // link stays silent once the limit is reached
			check_credits();
		end
		if (tlps_seen >= 3 * N_CH) begin
			for (int c = 0; c < N_CH; c++) begin
				if (ch_tlps[c] == 0)
					report_problem($sformatf("%s: channel %0d sent no TLP", cur_name, c));
			end
		end
		$display("row %s: %0d TLPs checked", cur_name, tlps_seen);
	endtask

	initial begin
		i_rst          = 1'b1;
		i_enable       = 1'b0;
		i_mps_code     = '0;
		i_requestor_id = '0;
		i_cred_lim_ph  = '0;
		i_cred_lim_pd  = '0;
		i_tx_ready     = 1'b1;
		seed           = 32'hafe82a5f;
		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- mempost_top.sv
`timescale 1ns/1ps

module mempost_top #(
	parameter int N_CH       = 3,
	parameter int FIFO_DEPTH = 128
) (
	input  logic                        w_AppClk,
	input  logic                        i_rst,
	input  logic                        i_enable,
	input  mempost_cfg_pkg::mps_code_t  i_mps_code,
	input  tlp_pkg::req_id_t            i_requestor_id,
	input  mempost_cfg_pkg::cred_hdr_t  i_cred_lim_ph,
	input  mempost_cfg_pkg::cred_data_t i_cred_lim_pd,
	output logic                        o_tx_valid,
	output logic                        o_tx_sop,
	output logic                        o_tx_eop,
	output tlp_pkg::qword_t             o_tx_data,
	input  logic                        i_tx_ready,
	output mempost_cfg_pkg::cred_hdr_t  o_cred_cons_ph,
	output mempost_cfg_pkg::cred_data_t o_cred_cons_pd
);
	import tlp_pkg::*;
	import mempost_cfg_pkg::*;

	logic [N_CH-1:0]   wr_en;     // source to channel fifos
	qword_t            wr_data;   // shared write bus
	logic [N_CH-1:0]   fifo_full;
	logic [N_CH-1:0]   req;
	logic [N_CH-1:0]   grant;
	logic [N_CH-1:0]   ch_valid;
	logic [N_CH-1:0]   ch_sop;
	logic [N_CH-1:0]   ch_eop;
	logic [N_CH-1:0]   ch_ready;
	qword_t [N_CH-1:0] ch_data;

	counter_source #(
		.N_CH (N_CH)
	) u_src (
		.w_AppClk    (w_AppClk),
		.i_rst       (i_rst),
		.i_enable    (i_enable),
		.i_fifo_full (fifo_full),
		.o_wr_en     (wr_en),
		.o_wr_data   (wr_data)
	);

	for (genvar c = 0; c < N_CH; c++) begin : g_ch
		mem_write_requestor #(
			.FIFO_DEPTH (FIFO_DEPTH),
			.CH_BASE    (ch_base(c))  // own 4k window per channel
		) u_req (
			.w_AppClk       (w_AppClk),
			.i_rst          (i_rst),
			.i_wr_en        (wr_en[c]),
			.i_wr_data      (wr_data),
			.o_fifo_full    (fifo_full[c]),
			.i_mps_code     (i_mps_code),
			.i_requestor_id (i_requestor_id),
			.o_req          (req[c]),
			.i_grant        (grant[c]),
			.o_tx_valid     (ch_valid[c]),
			.o_tx_sop       (ch_sop[c]),
			.o_tx_eop       (ch_eop[c]),
			.o_tx_data      (ch_data[c]),
			.i_tx_ready     (ch_ready[c])
		);
	end

	tx_credit_arbiter #(
		.N_CH (N_CH)
	) u_arb (
		.w_AppClk       (w_AppClk),
		.i_rst          (i_rst),
		.i_req          (req),
		.o_grant        (grant),
		.i_mps_code     (i_mps_code),
		.i_cred_lim_ph  (i_cred_lim_ph),
		.i_cred_lim_pd  (i_cred_lim_pd),
		.i_ch_valid     (ch_valid),
		.i_ch_sop       (ch_sop),
		.i_ch_eop       (ch_eop),
		.i_ch_data      (ch_data),
		.o_ch_ready     (ch_ready),
		.o_tx_valid     (o_tx_valid),
		.o_tx_sop       (o_tx_sop),
		.o_tx_eop       (o_tx_eop),
		.o_tx_data      (o_tx_data),
		.i_tx_ready     (i_tx_ready),
		.o_cred_cons_ph (o_cred_cons_ph),
		.o_cred_cons_pd (o_cred_cons_pd)
	);

endmodule

//--- tx_credit_arbiter.sv
`timescale 1ns/1ps

module tx_credit_arbiter #(
	parameter int N_CH = 3
) (
	input  logic                         w_AppClk,
	input  logic                         i_rst,
	input  logic [N_CH-1:0]              i_req,
	output logic [N_CH-1:0]              o_grant,
	input  mempost_cfg_pkg::mps_code_t   i_mps_code,
	input  mempost_cfg_pkg::cred_hdr_t   i_cred_lim_ph,  // posted header limit
	input  mempost_cfg_pkg::cred_data_t  i_cred_lim_pd,  // posted data limit
	input  logic [N_CH-1:0]              i_ch_valid,
	input  logic [N_CH-1:0]              i_ch_sop,
	input  logic [N_CH-1:0]              i_ch_eop,
	input  tlp_pkg::qword_t [N_CH-1:0]   i_ch_data,
	output logic [N_CH-1:0]              o_ch_ready,
	output logic                         o_tx_valid,
	output logic                         o_tx_sop,
	output logic                         o_tx_eop,
	output tlp_pkg::qword_t              o_tx_data,
	input  logic                         i_tx_ready,
	output mempost_cfg_pkg::cred_hdr_t   o_cred_cons_ph,  // cumulative, wraps mod 256
	output mempost_cfg_pkg::cred_data_t  o_cred_cons_pd   // cumulative, wraps mod 4096
);
	import mempost_cfg_pkg::*;

	cred_hdr_t       ph_avail;
	cred_data_t      pd_avail;
	cred_data_t      pd_need;   // data credits for one tlp
	logic            cred_ok;
	logic [N_CH-1:0] pick;

	assign pd_need  = cred_data_t'(mps_decode(i_mps_code) / CRED_DATA_BYTES);
	assign ph_avail = i_cred_lim_ph - o_cred_cons_ph;  // modular distance
	assign pd_avail = i_cred_lim_pd - o_cred_cons_pd;
	assign cred_ok  = (ph_avail != '0) && (pd_avail >= pd_need);
	assign pick     = i_req & (~i_req + 1'b1);         // lowest index requester

	always_ff @(posedge w_AppClk) begin
		if (i_rst) begin
			o_grant        <= '0;
			o_cred_cons_ph <= '0;
			o_cred_cons_pd <= '0;
		end else if (o_grant == '0) begin
			if ((i_req != '0) && cred_ok) begin
				o_grant        <= pick;
				o_cred_cons_ph <= o_cred_cons_ph + 1'b1; // charged at grant time
				o_cred_cons_pd <= o_cred_cons_pd + pd_need;
			end
		end else begin
			o_grant <= o_grant & i_req; // hold until owner drops its request
		end
	end

	// stream mux, granted channel only
	always_comb begin
		o_tx_data = '0;
		for (int c = 0; c < N_CH; c++) begin
			if (o_grant[c]) begin
				o_tx_data = i_ch_data[c];
			end
		end
	end

	assign o_tx_valid = |(o_grant & i_ch_valid);
	assign o_tx_sop   = |(o_grant & i_ch_sop);
	assign o_tx_eop   = |(o_grant & i_ch_eop);
	assign o_ch_ready = o_grant & {N_CH{i_tx_ready}}; // ready back to owner only

	// a second owner would interleave tlps on the link
	a_grant_onehot : assert property (@(posedge w_AppClk) disable iff (i_rst)
		$onehot0(o_grant));

endmodule

//--- mem_write_requestor.sv
`timescale 1ns/1ps

module mem_write_requestor #(
	parameter int           FIFO_DEPTH = 128,
	parameter tlp_pkg::dw_t CH_BASE    = 32'h0
) (
	input  logic                       w_AppClk,
	input  logic                       i_rst,
	input  logic                       i_wr_en,        // from counter source
	input  tlp_pkg::qword_t            i_wr_data,
	output logic                       o_fifo_full,
	input  mempost_cfg_pkg::mps_code_t i_mps_code,
	input  tlp_pkg::req_id_t           i_requestor_id,
	output logic                       o_req,          // level, to arbiter
	input  logic                       i_grant,        // level, held by arbiter
	output logic                       o_tx_valid,
	output logic                       o_tx_sop,
	output logic                       o_tx_eop,
	output tlp_pkg::qword_t            o_tx_data,
	input  logic                       i_tx_ready
);
	import tlp_pkg::*;
	import mempost_cfg_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [2:0] {
		IDLE,   // waiting for a full payload in the fifo
		REQ,    // asking the arbiter
		HDR0,   // dw1:dw0 on the bus
		HDR1,   // 0:dw2 on the bus
		DATA,   // payload qwords
		DONE    // request low, gap before next tlp
	} state_t;

	state_t        state;
	qword_t        fifo_data;
	logic          fifo_empty;
	logic [CW-1:0] fifo_count;
	logic          fifo_rd;
	pyld_bytes_t   mps_bytes;   // decoded live code
	pyld_bytes_t   pyld_bytes;  // size of the tlp in flight
	logic [8:0]    beats_left;  // data beats after the current one
	tag_t          tag;
	ch_ofs_t       ofs;         // running offset inside the window
	dw_t           dw0;
	dw_t           dw1;
	dw_t           dw2;

	sync_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.w_AppClk  (w_AppClk),
		.i_rst     (i_rst),
		.i_wr      (i_wr_en),
		.i_wr_data (i_wr_data),
		.i_rd      (fifo_rd),
		.o_rd_data (fifo_data),
		.o_full    (o_fifo_full),
		.o_empty   (fifo_empty),
		.o_count   (fifo_count)
	);

	assign mps_bytes = mps_decode(i_mps_code);

	// code only taken while idle, frozen for the whole tlp
	always_ff @(posedge w_AppClk) begin
		if (state == IDLE) begin
			pyld_bytes <= mps_bytes;
		end
	end

	always_ff @(posedge w_AppClk) begin
		if (i_rst) begin
			state      <= IDLE;
			beats_left <= '0;
			tag        <= '0;
			ofs        <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (32'(fifo_count) >= 32'(mps_bytes >> 3)) begin // whole payload buffered
						state <= REQ;
					end
				end
				REQ: begin
					if (i_grant) begin
						state <= HDR0;
					end
				end
				HDR0: begin
					if (i_tx_ready) begin
						state <= HDR1;
					end
				end
				HDR1: begin
					if (i_tx_ready) begin
						state      <= DATA;
						beats_left <= 9'(pyld_bytes >> 3) - 9'd1;
					end
				end
				DATA: begin
					if (i_tx_ready) begin
						if (beats_left == '0) begin // eop accepted
							state <= DONE;
							tag   <= tag + 1'b1;
							ofs   <= ch_ofs_t'((32'(ofs) + 32'(pyld_bytes)) % CH_WINDOW_BYTES);
						end else begin
							beats_left <= beats_left - 9'd1;
						end
					end
				end
				DONE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign dw0 = mwr_dw0(tlp_len_t'(pyld_bytes >> 2)); // length in dwords
	assign dw1 = mwr_dw1(i_requestor_id, tag);
	assign dw2 = CH_BASE + dw_t'(ofs);                 // qword aligned by construction

	assign o_req      = (state == REQ) || (state == HDR0) || (state == HDR1) || (state == DATA);
	assign o_tx_valid = (state == HDR0) || (state == HDR1) || (state == DATA);
	assign o_tx_sop   = (state == HDR0);
	assign o_tx_eop   = (state == DATA) && (beats_left == '0);
	assign fifo_rd    = (state == DATA) && i_tx_ready;  // pop only on accepted data beats

	always_comb begin
		case (state)
			HDR0:    o_tx_data = {dw1, dw0};
			HDR1:    o_tx_data = {32'h0, dw2};
			default: o_tx_data = fifo_data;
		endcase
	end

	// only the granted channel may drive the shared stream
	a_valid_granted : assert property (@(posedge w_AppClk) disable iff (i_rst)
		o_tx_valid |-> i_grant);

	// the idle check must keep the fifo ahead of the data phase
	a_data_avail : assert property (@(posedge w_AppClk) disable iff (i_rst)
		(state == DATA) |-> !fifo_empty);

endmodule

//--- counter_source.sv
`timescale 1ns/1ps

module counter_source #(
	parameter int N_CH = 3
) (
	input  logic            w_AppClk,
	input  logic            i_rst,
	input  logic            i_enable,
	input  logic [N_CH-1:0] i_fifo_full,
	output logic [N_CH-1:0] o_wr_en,
	output tlp_pkg::qword_t o_wr_data
);
	import tlp_pkg::*;

	localparam int            SW        = (N_CH > 1) ? $clog2(N_CH) : 1;
	localparam logic [SW-1:0] SLOT_LAST = SW'(N_CH - 1);

	logic [SW-1:0] slot;         // channel served this cycle
	qword_t        cnt [N_CH];   // next value per channel

	always_ff @(posedge w_AppClk) begin
		if (i_rst) begin
			slot <= '0;
		end else begin
			slot <= (slot == SLOT_LAST) ? '0 : slot + 1'b1; // rotates even when disabled
		end
	end

	always_comb begin
		for (int c = 0; c < N_CH; c++) begin
			o_wr_en[c] = i_enable && (slot == SW'(c)) && !i_fifo_full[c]; // full slot skipped
		end
	end

	assign o_wr_data = cnt[slot];

	always_ff @(posedge w_AppClk) begin
		for (int c = 0; c < N_CH; c++) begin
			if (i_rst) begin
				cnt[c] <= '0;
			end else if (o_wr_en[c]) begin
				cnt[c] <= cnt[c] + 1'b1; // advance only on a real write, no gaps
			end
		end
	end

	// one shared data bus, so at most one channel written per cycle
	a_wr_onehot : assert property (@(posedge w_AppClk) disable iff (i_rst)
		$onehot0(o_wr_en));

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int FIFO_DEPTH = 128
) (
	input  logic                            w_AppClk,
	input  logic                            i_rst,
	input  logic                            i_wr,
	input  tlp_pkg::qword_t                 i_wr_data,
	input  logic                            i_rd,
	output tlp_pkg::qword_t                 o_rd_data,
	output logic                            o_full,
	output logic                            o_empty,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] o_count
);
	import tlp_pkg::*;

	localparam int            AW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int            CW       = $clog2(FIFO_DEPTH + 1);
	localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);

	qword_t        mem [FIFO_DEPTH];  // no reset on storage
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = i_wr && !o_full;   // drop writes on full
	assign do_rd = i_rd && !o_empty;

	always_ff @(posedge w_AppClk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_wr_data;
		end
	end

	always_ff @(posedge w_AppClk) begin
		if (i_rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // wrap for any depth
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   o_count <= o_count + 1'b1;
				2'b01:   o_count <= o_count - 1'b1;
				default: o_count <= o_count; // idle or simultaneous rd/wr
			endcase
		end
	end

	assign o_rd_data = mem[rd_ptr];             // show-ahead head word
	assign o_full    = (o_count == CW'(FIFO_DEPTH));
	assign o_empty   = (o_count == '0);

	// producer and consumer must both honour the flags
	a_no_ovf_udf : assert property (@(posedge w_AppClk) disable iff (i_rst)
		!(i_rd && o_empty) && !(i_wr && o_full));

endmodule

//--- mempost_cfg_pkg.sv
package mempost_cfg_pkg;

	typedef logic [7:0]  cred_hdr_t;   // header credits
	typedef logic [11:0] cred_data_t;  // data credits, 16 bytes each
	typedef logic [2:0]  mps_code_t;   // devctl max payload field
	typedef logic [11:0] pyld_bytes_t; // payload size in bytes
	typedef logic [11:0] ch_ofs_t;     // byte offset inside one channel window

	localparam int          CRED_DATA_BYTES = 16;
	localparam int          CH_WINDOW_BYTES = 4096;           // per channel
	localparam logic [31:0] ADDR_BASE       = 32'h0001_0000;  // channel 0 window

	// max payload decode, unsupported codes fall back to 128
	function automatic pyld_bytes_t mps_decode(mps_code_t code);
		case (code)
			3'd0:    return 12'd128;
			3'd1:    return 12'd256;
			3'd2:    return 12'd512;
			default: return 12'd128;
		endcase
	endfunction

	// windows are laid out back to back above ADDR_BASE
	function automatic logic [31:0] ch_base(int unsigned c);
		return ADDR_BASE + 32'(c) * 32'(CH_WINDOW_BYTES);
	endfunction

endpackage

//--- tlp_pkg.sv
package tlp_pkg;

	typedef logic [31:0] dw_t;      // one header or payload dword
	typedef logic [63:0] qword_t;   // one beat of the tx stream
	typedef logic [7:0]  tag_t;     // request tag
	typedef logic [15:0] req_id_t;  // bus[15:8] dev[7:3] func[2:0]
	typedef logic [9:0]  tlp_len_t; // length field, in dwords

	localparam logic [2:0] FMT_MWR_3DW = 3'b010;   // 3dw header, with data
	localparam logic [4:0] TYPE_MEM    = 5'b00000; // memory request
	localparam logic [3:0] BE_ALL      = 4'hF;     // every byte enabled

	// header dword 0 of a posted write
	function automatic dw_t mwr_dw0(tlp_len_t len);
		return {
			FMT_MWR_3DW,  // [31:29]
			TYPE_MEM,     // [28:24]
			1'b0,         // reserved
			3'b000,       // tc 0
			4'b0000,      // reserved, attr2, th
			1'b0,         // td, no digest
			1'b0,         // ep
			2'b00,        // attr
			2'b00,        // at
			len           // [9:0]
		};
	endfunction

	// header dword 1, requester id + tag + byte enables
	function automatic dw_t mwr_dw1(req_id_t rid, tag_t tag);
		return {
			rid,     // [31:16]
			tag,     // [15:8]
			BE_ALL,  // last be
			BE_ALL   // first be
		};
	endfunction

endpackage
